// ==== verilog/chan_pkg.sv ====
`default_nettype none

package chan_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  // block address, byte offset already stripped
  localparam int ADDR_W = 26;
  // one cache line
  localparam int BLK_W  = 64;

  // ----------------------------------------------------------
  // opcodes
  // ----------------------------------------------------------
  // core side request kinds
  typedef enum logic [1:0] {
    CORE_RD  = 2'd0,
    CORE_RFO = 2'd1,
    CORE_WR  = 2'd2
  } core_op_e;

  // downstream request kinds
  typedef enum logic [1:0] {
    MEM_RD  = 2'd0,
    MEM_RFO = 2'd1,
    MEM_INV = 2'd2
  } mem_op_e;

  // ----------------------------------------------------------
  // channel payloads
  // ----------------------------------------------------------
  // core request, data only meaningful for a write
  typedef struct packed {
    core_op_e          op;
    logic [ADDR_W-1:0] addr;
    logic [BLK_W-1:0]  data;
  } core_req_t;

  // downstream request, no data on this channel
  typedef struct packed {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== verilog/coh_state_pkg.sv ====
`default_nettype none

package coh_state_pkg;

  import chan_pkg::*;

  // per-line coherence state
  typedef enum logic [1:0] {
    INVALID   = 2'd0,
    SHARED    = 2'd1,
    EXCLUSIVE = 2'd2,
    MODIFIED  = 2'd3
  } line_state_e;

  // downstream response kind
  // snoop means another cache holds a copy
  // fetch means we got the line alone
  typedef enum logic {
    RSP_SNOOP = 1'b0,
    RSP_FETCH = 1'b1
  } mem_rsp_e;

  typedef struct packed {
    mem_rsp_e         rsp;
    logic [BLK_W-1:0] data;
  } mem_rsp_t;

  // lookup result of the indexed line
  typedef struct packed {
    logic             hit;
    line_state_e      state;
    logic [BLK_W-1:0] data;
  } line_info_t;

  // single write port into the line array
  typedef struct packed {
    logic             en;
    line_state_e      state;
    logic [BLK_W-1:0] data;
  } line_wr_t;

endpackage

`default_nettype wire

// ==== verilog/core_req_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_req_buffer
  import chan_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  // core request channel
  input  wire logic      core_req_valid,
  input  wire core_req_t core_req,
  output logic           core_req_ready,
  // completion from the controller
  input  wire logic      done,
  // held request
  output logic           buf_valid,
  output core_req_t      buf_req
);

  logic accept;

  // one slot only, so accept just when empty
  assign core_req_ready = !buf_valid;
  assign accept         = core_req_valid && core_req_ready;

  // ----------------------------------------------------------
  // occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_valid <= 1'b0;
    end else if (done) begin
      // response handshake frees the slot
      buf_valid <= 1'b0;
    end else if (accept) begin
      buf_valid <= 1'b1;
    end
  end

  // payload, held until done
  always_ff @(posedge clk) begin
    if (accept) begin
      buf_req <= core_req;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/line_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_array
  import chan_pkg::*;
  import coh_state_pkg::*;
#(
  parameter int NUM_BLK = 16
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  // buffered block address
  input  wire logic [ADDR_W-1:0] addr,
  // lookup result, combinational
  output line_info_t       info,
  // update port
  input  wire line_wr_t    wr
);

  // ----------------------------------------------------------
  // address split
  // ----------------------------------------------------------
  localparam int IDX_W = $clog2(NUM_BLK);
  localparam int TAG_W = ADDR_W - IDX_W;

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;

  // low bits index, the rest is tag
  assign idx = addr[IDX_W-1:0];
  assign tag = addr[ADDR_W-1:IDX_W];

  // ----------------------------------------------------------
  // storage
  // ----------------------------------------------------------
  line_state_e      state_q [NUM_BLK];
  logic [TAG_W-1:0] tag_q   [NUM_BLK];
  logic [BLK_W-1:0] data_q  [NUM_BLK];

  // states come up invalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_BLK; i++) begin
        state_q[i] <= INVALID;
      end
    end else if (wr.en) begin
      state_q[idx] <= wr.state;
    end
  end

  // tag and data follow the same write
  always_ff @(posedge clk) begin
    if (wr.en) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= wr.data;
    end
  end

  // ----------------------------------------------------------
  // lookup
  // ----------------------------------------------------------
  // hit needs a valid state and a matching tag
  assign info.hit   = (state_q[idx] != INVALID) && (tag_q[idx] == tag);
  assign info.state = state_q[idx];
  assign info.data  = data_q[idx];

endmodule

`default_nettype wire

// ==== verilog/coherence_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module coherence_ctrl
  import chan_pkg::*;
  import coh_state_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst_n,
  // from the request buffer and the line array
  input  wire logic       buf_valid,
  input  wire core_req_t  buf_req,
  input  wire line_info_t info,
  output line_wr_t        line_wr,
  output logic            done,
  // downstream request
  output logic            mem_req_valid,
  output mem_req_t        mem_req,
  input  wire logic       mem_req_ready,
  // downstream response
  input  wire logic       mem_rsp_valid,
  input  wire mem_rsp_t   mem_rsp,
  output logic            mem_rsp_ready,
  // core response
  output logic            core_rsp_valid,
  output logic [BLK_W-1:0] core_rsp_data,
  input  wire logic       core_rsp_ready
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    MEM_REQ,
    MEM_WAIT,
    RESPOND
  } ctrl_state_e;

  ctrl_state_e      state_q;
  ctrl_state_e      state_d;
  mem_op_e          mem_op_q;
  mem_op_e          lookup_op;
  mem_rsp_e         fill_rsp_q;
  logic [BLK_W-1:0] fill_data_q;
  logic             want_own;
  logic             own_hit;
  logic             skip_mem;
  logic             req_hs;
  logic             rsp_hs;
  logic             core_hs;
  logic [BLK_W-1:0] line_data;
  line_state_e      new_state;

  // ----------------------------------------------------------
  // lookup decision
  // ----------------------------------------------------------
  // rfo and write both need ownership
  assign want_own = (buf_req.op == CORE_RFO) || (buf_req.op == CORE_WR);
  assign own_hit  = info.hit && ((info.state == EXCLUSIVE) || (info.state == MODIFIED));
  assign skip_mem = want_own ? own_hit : info.hit;

  // shared hit needs only an upgrade
  always_comb begin
    if (!want_own) begin
      lookup_op = MEM_RD;
    end else if (info.hit) begin
      lookup_op = MEM_INV;
    end else begin
      lookup_op = MEM_RFO;
    end
  end

  // handshakes
  assign req_hs  = mem_req_valid && mem_req_ready;
  assign rsp_hs  = mem_rsp_valid && mem_rsp_ready;
  assign core_hs = core_rsp_valid && core_rsp_ready;

  // ----------------------------------------------------------
  // fsm
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (buf_valid) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        state_d = skip_mem ? RESPOND : MEM_REQ;
      end
      MEM_REQ: begin
        if (req_hs) begin
          state_d = MEM_WAIT;
        end
      end
      MEM_WAIT: begin
        if (rsp_hs) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (core_hs) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // opcode latched once, held through MEM_REQ
  always_ff @(posedge clk) begin
    if (state_q == LOOKUP) begin
      mem_op_q <= lookup_op;
    end
  end

  // fill capture at the downstream response
  always_ff @(posedge clk) begin
    if (rsp_hs) begin
      fill_rsp_q  <= mem_rsp.rsp;
      fill_data_q <= mem_rsp.data;
    end
  end

  // ----------------------------------------------------------
  // channel outputs
  // ----------------------------------------------------------
  assign mem_req_valid = (state_q == MEM_REQ);
  assign mem_req.op    = mem_op_q;
  assign mem_req.addr  = buf_req.addr;
  assign mem_rsp_ready = (state_q == MEM_WAIT);

  // array is untouched until the handshake, so hit stays valid here
  // upgrade keeps the local copy, a miss takes the fill
  assign line_data      = info.hit ? info.data : fill_data_q;
  assign core_rsp_valid = (state_q == RESPOND);
  assign core_rsp_data  = (buf_req.op == CORE_WR) ? '0 : line_data;
  assign done           = core_hs;

  // ----------------------------------------------------------
  // line update
  // ----------------------------------------------------------
  always_comb begin
    if (buf_req.op != CORE_RD) begin
      new_state = MODIFIED;
    end else if (info.hit) begin
      new_state = info.state;
    end else if (fill_rsp_q == RSP_SNOOP) begin
      new_state = SHARED;
    end else begin
      new_state = EXCLUSIVE;
    end
  end

  // write replaces the whole line
  assign line_wr.en    = core_hs;
  assign line_wr.state = new_state;
  assign line_wr.data  = (buf_req.op == CORE_WR) ? buf_req.data : line_data;

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_top
  import chan_pkg::*;
  import coh_state_pkg::*;
#(
  parameter int NUM_BLK = 16
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  // core request
  input  wire logic        core_req_valid,
  input  wire core_req_t   core_req,
  output logic             core_req_ready,
  // core response
  output logic             core_rsp_valid,
  output logic [BLK_W-1:0] core_rsp_data,
  input  wire logic        core_rsp_ready,
  // downstream request
  output logic             mem_req_valid,
  output mem_req_t         mem_req,
  input  wire logic        mem_req_ready,
  // downstream response
  input  wire logic        mem_rsp_valid,
  input  wire mem_rsp_t    mem_rsp,
  output logic             mem_rsp_ready
);

  logic       buf_valid;
  core_req_t  buf_req;
  line_info_t info;
  line_wr_t   line_wr;
  logic       done;

  // ----------------------------------------------------------
  // capture
  // ----------------------------------------------------------
  core_req_buffer u_buf (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_req_valid (core_req_valid),
    .core_req       (core_req),
    .core_req_ready (core_req_ready),
    .done           (done),
    .buf_valid      (buf_valid),
    .buf_req        (buf_req)
  );

  // ----------------------------------------------------------
  // lookup
  // ----------------------------------------------------------
  line_array #(
    .NUM_BLK (NUM_BLK)
  ) u_lines (
    .clk   (clk),
    .rst_n (rst_n),
    .addr  (buf_req.addr),
    .info  (info),
    .wr    (line_wr)
  );

  // ----------------------------------------------------------
  // coherence control
  // ----------------------------------------------------------
  coherence_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .buf_valid      (buf_valid),
    .buf_req        (buf_req),
    .info           (info),
    .line_wr        (line_wr),
    .done           (done),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp        (mem_rsp),
    .mem_rsp_ready  (mem_rsp_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_data  (core_rsp_data),
    .core_rsp_ready (core_rsp_ready)
  );

endmodule

`default_nettype wire

// ==== tests/cache_ctrl_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_chk
  import chan_pkg::*;
(
  input wire logic             clk,
  input wire logic             rst_n,
  input wire logic             core_req_ready,
  input wire logic             core_rsp_valid,
  input wire logic             core_rsp_ready,
  input wire logic [BLK_W-1:0] core_rsp_data,
  input wire logic             mem_req_valid,
  input wire logic             mem_req_ready,
  input wire mem_req_t         mem_req
);

  // count of failed handshake rules
  int unsigned fail_cnt = 0;

  // ----------------------------------------------------------
  // handshake rules
  // ----------------------------------------------------------
  // downstream request held until taken
  mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
  else begin
    fail_cnt++;
    $error("mem_req dropped or changed before mem_req_ready");
  end

  // core response held until taken
  core_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp_data))
  else begin
    fail_cnt++;
    $error("core response dropped or changed before core_rsp_ready");
  end

  // slot busy while responding
  req_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    core_rsp_valid |-> !core_req_ready)
  else begin
    fail_cnt++;
    $error("core_req_ready high during a core response");
  end

endmodule

bind cache_ctrl_top cache_ctrl_chk chk_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .core_req_ready (core_req_ready),
  .core_rsp_valid (core_rsp_valid),
  .core_rsp_ready (core_rsp_ready),
  .core_rsp_data  (core_rsp_data),
  .mem_req_valid  (mem_req_valid),
  .mem_req_ready  (mem_req_ready),
  .mem_req        (mem_req)
);

`default_nettype wire

// ==== tests/cache_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_tb
  import chan_pkg::*;
  import coh_state_pkg::*;
();

  localparam int NUM_BLK = 16;
  localparam int TIMEOUT = 200;

  // ----------------------------------------------------------
  // dut inputs, all start at a known value
  // ----------------------------------------------------------
  logic             clk            = 1'b0;
  logic             rst_n          = 1'b0;
  logic             core_req_valid = 1'b0;
  core_req_t        core_req       = '0;
  logic             core_rsp_ready = 1'b0;
  logic             mem_req_ready  = 1'b0;
  logic             mem_rsp_valid  = 1'b0;
  mem_rsp_t         mem_rsp        = '0;

  // dut outputs
  logic             core_req_ready;
  logic             core_rsp_valid;
  logic [BLK_W-1:0] core_rsp_data;
  logic             mem_req_valid;
  mem_req_t         mem_req;
  logic             mem_rsp_ready;

  // responder and stall control
  logic             stall_on       = 1'b0;
  mem_rsp_e         cur_rsp        = RSP_SNOOP;
  logic [BLK_W-1:0] cur_fill       = '0;
  logic [31:0]      rng            = 32'd68;
  int               mem_req_count  = 0;
  logic [1:0]       seen_op        = '0;
  logic [ADDR_W-1:0] seen_addr     = '0;

  // bookkeeping
  int               errors         = 0;
  int               tests_run      = 0;
  logic             aborted        = 1'b0;

  // 8 ns period
  always #4 clk = ~clk;

  cache_ctrl_top #(
    .NUM_BLK (NUM_BLK)
  ) dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_req_valid (core_req_valid),
    .core_req       (core_req),
    .core_req_ready (core_req_ready),
    .core_rsp_valid (core_rsp_valid),
    .core_rsp_data  (core_rsp_data),
    .core_rsp_ready (core_rsp_ready),
    .mem_req_valid  (mem_req_valid),
    .mem_req        (mem_req),
    .mem_req_ready  (mem_req_ready),
    .mem_rsp_valid  (mem_rsp_valid),
    .mem_rsp        (mem_rsp),
    .mem_rsp_ready  (mem_rsp_ready)
  );

  // xorshift32 step
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ----------------------------------------------------------
  // ready generation, random only for stall vectors
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      core_rsp_ready <= 1'b0;
      mem_req_ready  <= 1'b0;
    end else if (stall_on) begin
      rng            <= next_rand(rng);
      // roughly three in four cycles ready
      core_rsp_ready <= rng[3] | rng[9];
      mem_req_ready  <= rng[14] | rng[22];
    end else begin
      core_rsp_ready <= 1'b1;
      mem_req_ready  <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // downstream responder
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_rsp_valid <= 1'b0;
    end else begin
      if (mem_rsp_valid && mem_rsp_ready) begin
        mem_rsp_valid <= 1'b0;
      end
      // answer with the current vector's kind and fill
      if (mem_req_valid && mem_req_ready) begin
        seen_op       <= mem_req.op;
        seen_addr     <= mem_req.addr;
        mem_req_count <= mem_req_count + 1;
        mem_rsp_valid <= 1'b1;
        mem_rsp.rsp   <= cur_rsp;
        mem_rsp.data  <= cur_fill;
      end
    end
  end

  // idle outputs right after reset
  task automatic check_reset_state();
    int errors_before;
    errors_before = errors;
    assert (core_req_ready && !core_rsp_valid && !mem_req_valid && !mem_rsp_ready) else begin
      $display("outputs not in their idle values after reset");
      errors++;
    end
    $display("test reset %s", (errors == errors_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------------------------
  // one vector, request to response
  // ----------------------------------------------------------
  task automatic run_test(input int id, input logic [1:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [BLK_W-1:0] wdata, input logic [3:0] mop, input logic rsp,
                          input logic [BLK_W-1:0] fill, input logic [BLK_W-1:0] exp,
                          input logic stall);
    int               errors_before;
    int               start_count;
    int               cycles;
    int               rise_edge;
    logic             got_rsp;
    logic [BLK_W-1:0] got;
    core_req_t        req;
    errors_before = errors;
    start_count   = mem_req_count;
    tests_run++;
    req.op   = core_op_e'(op);
    req.addr = addr;
    req.data = wdata;
    @(posedge clk);
    cur_rsp        <= mem_rsp_e'(rsp);
    cur_fill       <= fill;
    stall_on       <= stall;
    core_req_valid <= 1'b1;
    core_req       <= req;
    // accept handshake
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!core_req_ready && cycles < TIMEOUT);
    core_req_valid <= 1'b0;
    assert (core_req_ready) else begin
      $display("test %0d: request not accepted within %0d cycles", id, TIMEOUT);
      errors++;
      aborted = 1'b1;
      return;
    end
    // response handshake, edges counted from acceptance
    cycles    = 0;
    rise_edge = -1;
    got_rsp   = 1'b0;
    got       = '0;
    while (!got_rsp && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      if (core_rsp_valid && rise_edge < 0) begin
        rise_edge = cycles - 1;
      end
      if (core_rsp_valid && core_rsp_ready) begin
        got     = core_rsp_data;
        got_rsp = 1'b1;
      end
    end
    assert (got_rsp) else begin
      $display("test %0d: no core response within %0d cycles", id, TIMEOUT);
      errors++;
      aborted = 1'b1;
      return;
    end
    assert (got == exp) else begin
      $display("Mismatch at %0t: core_rsp_data got %h expected %h", $time, got, exp);
      errors++;
    end
    // downstream traffic of this vector
    if (mop == 4'h3) begin
      assert (mem_req_count == start_count) else begin
        $display("test %0d: unexpected downstream request", id);
        errors++;
      end
    end else begin
      assert (mem_req_count == start_count + 1) else begin
        $display("test %0d: expected one downstream request, saw %0d", id,
                 mem_req_count - start_count);
        errors++;
      end
      assert (seen_op == mop[1:0]) else begin
        $display("Mismatch at %0t: mem_req.op got %0d expected %0d", $time, seen_op, mop);
        errors++;
      end
      assert (seen_addr == addr) else begin
        $display("Mismatch at %0t: mem_req.addr got %h expected %h", $time, seen_addr, addr);
        errors++;
      end
    end
    // plain hit with ready held high
    if (mop == 4'h3 && !stall) begin
      assert (rise_edge == 2) else begin
        $display("Mismatch at %0t: core_rsp_valid rise edge got %0d expected 2", $time,
                 rise_edge);
        errors++;
      end
    end
    @(posedge clk);
    assert (core_req_ready) else begin
      $display("test %0d: core_req_ready not high after the response", id);
      errors++;
    end
    $display("test %0d %s", id, (errors == errors_before) ? "ok" : "failed");
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial begin
    int                fd;
    int                n;
    string             line;
    int                v_id;
    logic [1:0]        v_op;
    logic [ADDR_W-1:0] v_addr;
    logic [BLK_W-1:0]  v_wdata;
    logic [3:0]        v_mop;
    logic              v_rsp;
    logic [BLK_W-1:0]  v_fill;
    logic [BLK_W-1:0]  v_exp;
    logic              v_stall;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_state();
    fd = $fopen("tests/cache_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/cache_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !aborted) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          // comment and blank lines do not scan
          n = $sscanf(line, "%d %h %h %h %h %h %h %h %h", v_id, v_op, v_addr, v_wdata,
                      v_mop, v_rsp, v_fill, v_exp, v_stall);
          if (n == 9) begin
            run_test(v_id, v_op, v_addr, v_wdata, v_mop, v_rsp, v_fill, v_exp, v_stall);
          end
        end
      end
      $fclose(fd);
    end
    assert (dut_i.chk_i.fail_cnt == 0) else begin
      $display("handshake assertions failed %0d times", dut_i.chk_i.fail_cnt);
      errors++;
    end
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0 && tests_run > 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/cache_vectors.txt ====
# id(dec) op addr wdata mem_op rsp fill expect stall, all but id in hex
# op 0 rd 1 rfo 2 wr; mem_op 0 rd 1 rfo 2 inv 3 none; rsp 0 snoop 1 fetch
1 0 0000010 0 0 0 1111111111111111 1111111111111111 0
2 0 0000010 0 3 0 0 1111111111111111 0
3 1 0000010 0 2 1 0 1111111111111111 0
4 0 0000021 0 0 1 2222222222222222 2222222222222222 0
5 1 0000021 0 3 0 0 2222222222222222 0
6 2 0000032 aaaaaaaaaaaaaaaa 1 1 3333333333333333 0 0
7 0 0000032 0 3 0 0 aaaaaaaaaaaaaaaa 0
8 2 0000032 bbbbbbbbbbbbbbbb 3 0 0 0 0
9 0 0000032 0 3 0 0 bbbbbbbbbbbbbbbb 0
10 0 0000045 0 0 1 4444444444444444 4444444444444444 0
11 0 0000055 0 0 0 5555555555555555 5555555555555555 0
12 0 0000045 0 0 1 4646464646464646 4646464646464646 0
13 2 0000067 cccccccccccccccc 1 0 6666666666666666 0 1
14 0 0000067 0 3 0 0 cccccccccccccccc 1
15 0 0000078 0 0 0 7777777777777777 7777777777777777 1
16 1 0000078 0 2 0 0 7777777777777777 1
17 0 0000178 0 0 1 8888888888888888 8888888888888888 1
18 0 0000078 0 0 0 7979797979797979 7979797979797979 1

// ==== all.f ====
verilog/chan_pkg.sv
verilog/coh_state_pkg.sv
verilog/core_req_buffer.sv
verilog/line_array.sv
verilog/coherence_ctrl.sv
verilog/cache_ctrl_top.sv
tests/cache_ctrl_chk.sv
tests/cache_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_ctrl_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
